/* list.f */
+incdir+design
design/sa_pkg.sv
design/dram_row_packer.sv
design/row_memory.sv
design/dot_product_pipe.sv
design/pe_array.sv
design/sa_controller.sv
design/result_fifo.sv
design/conv_engine_top.sv
dv/tb_conv_engine.sv

/* run.sh */
#!/bin/sh
# build and run the convolution engine testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_conv_engine -f list.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* dv/tb_conv_engine.sv */
`timescale 1ns/1ps
`include "sa_cfg.svh"

module tb_conv_engine
    import sa_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic       clk_i;
    logic       rd_weight_rst;
    logic       load_valid_i;
    load_beat_t load_beat_i;
    logic       load_ready_o;
    logic       job_valid_i;
    job_req_t   job_i;
    logic       job_ready_o;
    logic       res_valid_o;
    result_t    res_o;
    logic       res_ready_i;

    // shadow copies of what the memories should hold
    mem_row_t    feat_sh [`SA_FEAT_DEPTH];
    mem_row_t    wgt_sh  [`SA_WGT_DEPTH];
    logic [31:0] lfsr_q;
    int          n_checks;
    int          n_errors;
    int          n_tests;

    conv_engine_top uut (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .load_valid_i  (load_valid_i),
        .load_beat_i   (load_beat_i),
        .load_ready_o  (load_ready_o),
        .job_valid_i   (job_valid_i),
        .job_i         (job_i),
        .job_ready_o   (job_ready_o),
        .res_valid_o   (res_valid_o),
        .res_o         (res_o),
        .res_ready_i   (res_ready_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    ////////////////////
    // reference model
    ////////////////////

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
        end
        return v;
    endfunction

    function automatic mem_row_t random_row();
        mem_row_t    r;
        logic [31:0] v;
        for (int k = 0; k < `SA_ROWS; k++) begin
            v         = next_bits(`SA_DATA_W);
            r.lane[k] = v[`SA_DATA_W-1:0];
        end
        return r;
    endfunction

    // signed dot product, kept to 16 bits
    function automatic logic [15:0] dot16(input mem_row_t f, input mem_row_t w);
        int acc;
        int a;
        int b;
        acc = 0;
        for (int k = 0; k < `SA_ROWS; k++) begin
            a   = $signed(f.lane[k]);
            b   = $signed(w.lane[k]);
            acc = acc + a * b;
        end
        return acc[15:0];
    endfunction

    function automatic logic [63:0] expected_sums(input int row);
        logic [63:0] e;
        for (int c = 0; c < `SA_COLS; c++) begin
            e[c*16 +: 16] = dot16(feat_sh[row], wgt_sh[c]);
        end
        return e;
    endfunction

    ////////////////////
    // checks and drivers
    ////////////////////

    task automatic timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        n_checks++;
        assert (exp == act) else begin
            n_errors++;
            $display("Mismatch %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    task automatic finish_test(input string name, input int err_start);
        n_tests++;
        $display("test %s done, %0d errors", name, n_errors - err_start);
    endtask

    // called on a falling edge, returns on one
    task automatic send_beat(input load_beat_t b);
        int waited;
        waited       = 0;
        load_valid_i = 1'b1;
        load_beat_i  = b;
        while (!load_ready_o) begin
            @(negedge clk_i);
            waited++;
            if (waited > TIMEOUT) timeout("load ready");
        end
        @(negedge clk_i);
        load_valid_i = 1'b0;
    endtask

    task automatic load_row(input logic is_wgt, input mem_row_t row);
        logic [127:0] flat;
        load_beat_t   b;
        flat = row;
        for (int i = 0; i < `SA_BEATS_PER_ROW; i++) begin
            b.is_wgt = is_wgt;
            b.data   = flat[i*`SA_BEAT_W +: `SA_BEAT_W];
            send_beat(b);
        end
    endtask

    task automatic load_weights();
        for (int c = 0; c < `SA_WGT_DEPTH; c++) begin
            wgt_sh[c] = random_row();
            load_row(1'b1, wgt_sh[c]);
        end
    endtask

    task automatic load_features(input int n);
        for (int r = 0; r < n; r++) begin
            feat_sh[r] = random_row();
            load_row(1'b0, feat_sh[r]);
        end
    endtask

    task automatic send_job(input int n);
        int waited;
        waited         = 0;
        job_valid_i    = 1'b1;
        job_i.num_rows = n[4:0];
        while (!job_ready_o) begin
            @(negedge clk_i);
            waited++;
            if (waited > TIMEOUT) timeout("job ready");
        end
        @(negedge clk_i);
        job_valid_i = 1'b0;
    endtask

    // pops n results and compares each against the model
    task automatic collect(input string name, input int n, input logic use_random);
        int          got;
        int          waited;
        result_t     r;
        logic [31:0] v;
        got    = 0;
        waited = 0;
        while (got < n) begin
            v           = next_bits(1);
            res_ready_i = use_random ? v[0] : 1'b1;
            if (res_valid_o && res_ready_i) begin
                r = res_o;
                check_val({name, " sums"}, expected_sums(got), r.sum);
                check_val({name, " row index"}, 64'(got), 64'(r.row_idx));
                check_val({name, " last"}, 64'(got == n - 1), 64'(r.last));
                got++;
                waited = 0;
            end else begin
                waited++;
                if (waited > TIMEOUT) timeout({name, " result"});
            end
            @(negedge clk_i);
        end
        res_ready_i = 1'b0;
        check_val({name, " extra result"}, 64'd0, 64'(res_valid_o));
    endtask

    ////////////////////
    // protocol assertions
    ////////////////////

    a_load_blocked: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        !job_ready_o |-> !load_ready_o)
        else begin
            n_errors++;
            $display("load stream was ready while a job was running");
        end

    a_res_held: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o))
        else begin
            n_errors++;
            $display("result changed or vanished while the stream was stalled");
        end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        int e0;
        lfsr_q        = 32'h80642866;
        n_checks      = 0;
        n_errors      = 0;
        n_tests       = 0;
        rd_weight_rst = 1'b1;
        load_valid_i  = 1'b0;
        load_beat_i   = '0;
        job_valid_i   = 1'b0;
        job_i         = '0;
        res_ready_i   = 1'b0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rd_weight_rst = 1'b0;
        @(negedge clk_i);

        e0 = n_errors;
        check_val("reset res_valid", 64'd0, 64'(res_valid_o));
        check_val("reset job_ready", 64'd1, 64'(job_ready_o));
        check_val("reset load_ready", 64'd1, 64'(load_ready_o));
        finish_test("reset", e0);

        e0 = n_errors;
        load_weights();
        load_features(1);
        send_job(1);
        collect("single row", 1, 1'b0);
        finish_test("single row", e0);

        e0 = n_errors;
        load_features(16);
        send_job(16);
        collect("full job", 16, 1'b0);
        finish_test("full job", e0);

        // rows 12 to 15 keep older data and go unused
        e0 = n_errors;
        load_features(12);
        send_job(12);
        collect("back-pressure", 12, 1'b1);
        finish_test("back-pressure", e0);

        // feature rows 0..4 from the previous load stay in place
        e0 = n_errors;
        load_weights();
        send_job(5);
        check_val("reload load_ready busy", 64'd0, 64'(load_ready_o));
        collect("reload", 5, 1'b0);
        finish_test("reload", e0);

        $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* design/conv_engine_top.sv */
`timescale 1ns/1ps
`include "sa_cfg.svh"

module conv_engine_top
    import sa_pkg::*;
(
    input  logic       clk_i,
    input  logic       rd_weight_rst,
    input  logic       load_valid_i,
    input  load_beat_t load_beat_i,
    output logic       load_ready_o,
    input  logic       job_valid_i,
    input  job_req_t   job_i,
    output logic       job_ready_o,
    output logic       res_valid_o,
    output result_t    res_o,
    input  logic       res_ready_i
);

    logic                                feat_we;
    logic [$clog2(`SA_FEAT_DEPTH)-1:0]   feat_waddr;
    logic                                wgt_we;
    logic [$clog2(`SA_WGT_DEPTH)-1:0]    wgt_waddr;
    mem_row_t                            wr_row;
    logic                                busy;
    logic                                feat_re;
    logic [$clog2(`SA_FEAT_DEPTH)-1:0]   feat_raddr;
    logic                                wgt_re;
    logic [$clog2(`SA_WGT_DEPTH)-1:0]    wgt_raddr;
    mem_row_t                            feat_row;
    mem_row_t                            wgt_row;
    logic [`SA_COLS-1:0]                 wgt_load;
    logic                                feat_valid;
    logic                                sum_valid;
    logic [`SA_COLS*`SA_RES_W-1:0]       sums;
    logic                                fifo_push;
    result_t                             fifo_data;
    logic [$clog2(`SA_FIFO_DEPTH+1)-1:0] fifo_count;

    ////////////////////
    // load path
    ////////////////////

    dram_row_packer u_packer (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .load_valid_i  (load_valid_i),
        .load_beat_i   (load_beat_i),
        .busy_i        (busy),
        .load_ready_o  (load_ready_o),
        .feat_we_o     (feat_we),
        .feat_waddr_o  (feat_waddr),
        .wgt_we_o      (wgt_we),
        .wgt_waddr_o   (wgt_waddr),
        .row_o         (wr_row)
    );

    row_memory #(.DEPTH(`SA_FEAT_DEPTH)) u_feat_mem (
        .clk_i   (clk_i),
        .we_i    (feat_we),
        .waddr_i (feat_waddr),
        .wdata_i (wr_row),
        .re_i    (feat_re),
        .raddr_i (feat_raddr),
        .rdata_o (feat_row)
    );

    row_memory #(.DEPTH(`SA_WGT_DEPTH)) u_wgt_mem (
        .clk_i   (clk_i),
        .we_i    (wgt_we),
        .waddr_i (wgt_waddr),
        .wdata_i (wr_row),
        .re_i    (wgt_re),
        .raddr_i (wgt_raddr),
        .rdata_o (wgt_row)
    );

    ////////////////////
    // compute and output
    ////////////////////

    pe_array u_array (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .wgt_load_i    (wgt_load),
        .wgt_row_i     (wgt_row),
        .feat_valid_i  (feat_valid),
        .feat_row_i    (feat_row),
        .sum_valid_o   (sum_valid),
        .sums_o        (sums)
    );

    sa_controller u_ctrl (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .job_valid_i   (job_valid_i),
        .job_i         (job_i),
        .sum_valid_i   (sum_valid),
        .sums_i        (sums),
        .fifo_count_i  (fifo_count),
        .job_ready_o   (job_ready_o),
        .busy_o        (busy),
        .feat_re_o     (feat_re),
        .feat_raddr_o  (feat_raddr),
        .wgt_re_o      (wgt_re),
        .wgt_raddr_o   (wgt_raddr),
        .wgt_load_o    (wgt_load),
        .feat_valid_o  (feat_valid),
        .fifo_push_o   (fifo_push),
        .fifo_data_o   (fifo_data)
    );

    result_fifo u_fifo (
        .clk_i         (clk_i),
        .rd_weight_rst (rd_weight_rst),
        .push_i        (fifo_push),
        .push_data_i   (fifo_data),
        .res_ready_i   (res_ready_i),
        .res_valid_o   (res_valid_o),
        .res_o         (res_o),
        .count_o       (fifo_count)
    );

endmodule

/* design/result_fifo.sv */
`timescale 1ns/1ps
`include "sa_cfg.svh"

module result_fifo
    import sa_pkg::*;
(
    input  logic                                clk_i,
    input  logic                                rd_weight_rst,
    input  logic                                push_i,
    input  result_t                             push_data_i,
    input  logic                                res_ready_i,
    output logic                                res_valid_o,
    output result_t                             res_o,
    output logic [$clog2(`SA_FIFO_DEPTH+1)-1:0] count_o
);

    localparam int PTR_W = $clog2(`SA_FIFO_DEPTH);

    result_t          buf_q [`SA_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic             pop;

    assign res_valid_o = (count_o != '0);
    assign res_o       = buf_q[rd_ptr_q];
    assign pop         = res_valid_o && res_ready_i;

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            for (int i = 0; i < `SA_FIFO_DEPTH; i++) buf_q[i] <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_o  <= '0;
        end else begin
            if (push_i) begin
                buf_q[wr_ptr_q] <= push_data_i;
                wr_ptr_q        <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            case ({push_i, pop})
                2'b10:   count_o <= count_o + 1'b1;
                2'b01:   count_o <= count_o - 1'b1;
                default: count_o <= count_o;
            endcase
        end
    end

    a_hold_stalled: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        res_valid_o && !res_ready_i |=> $stable(res_o));

endmodule

/* design/sa_controller.sv */
`timescale 1ns/1ps
`include "sa_cfg.svh"

module sa_controller
    import sa_pkg::*;
(
    input  logic                                 clk_i,
    input  logic                                 rd_weight_rst,
    input  logic                                 job_valid_i,
    input  job_req_t                             job_i,
    input  logic                                 sum_valid_i,
    input  logic [`SA_COLS*`SA_RES_W-1:0]        sums_i,
    input  logic [$clog2(`SA_FIFO_DEPTH+1)-1:0]  fifo_count_i,
    output logic                                 job_ready_o,
    output logic                                 busy_o,
    output logic                                 feat_re_o,
    output logic [$clog2(`SA_FEAT_DEPTH)-1:0]    feat_raddr_o,
    output logic                                 wgt_re_o,
    output logic [$clog2(`SA_WGT_DEPTH)-1:0]     wgt_raddr_o,
    output logic [`SA_COLS-1:0]                  wgt_load_o,
    output logic                                 feat_valid_o,
    output logic                                 fifo_push_o,
    output result_t                              fifo_data_o
);

    localparam int ROW_W = $clog2(`SA_FEAT_DEPTH + 1);
    localparam int WA_W  = $clog2(`SA_WGT_DEPTH);
    localparam logic [WA_W-1:0] LAST_WGT = WA_W'(`SA_WGT_DEPTH - 1);

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_WFETCH = 2'd1;
    localparam logic [1:0] S_STREAM = 2'd2;

    logic [1:0]       state_q;
    logic [ROW_W-1:0] num_rows_q;
    logic [WA_W-1:0]  wcnt_q;
    logic [ROW_W-1:0] issued_q;
    logic [ROW_W-1:0] done_q;
    logic [ROW_W-1:0] in_flight;
    logic [ROW_W:0]   occupancy;
    logic             last_row;

    ////////////////////
    // credit and issue
    ////////////////////

    // rows in the pipe still need a FIFO slot
    assign in_flight = issued_q - done_q;
    assign occupancy = (ROW_W+1)'(fifo_count_i) + (ROW_W+1)'(in_flight);

    assign job_ready_o  = (state_q == S_IDLE);
    assign busy_o       = !job_ready_o;
    assign wgt_re_o     = (state_q == S_WFETCH);
    assign wgt_raddr_o  = wcnt_q;
    assign feat_re_o    = (state_q == S_STREAM) && (issued_q < num_rows_q)
                          && (occupancy < `SA_FIFO_DEPTH);
    assign feat_raddr_o = issued_q[$clog2(`SA_FEAT_DEPTH)-1:0];

    // label results in completion order
    assign last_row            = (done_q == num_rows_q - 1'b1);
    assign fifo_push_o         = sum_valid_i;
    assign fifo_data_o.sum     = sums_i;
    assign fifo_data_o.row_idx = done_q[$clog2(`SA_FEAT_DEPTH)-1:0];
    assign fifo_data_o.last    = last_row;

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            state_q      <= S_IDLE;
            num_rows_q   <= '0;
            wcnt_q       <= '0;
            issued_q     <= '0;
            done_q       <= '0;
            wgt_load_o   <= '0;
            feat_valid_o <= 1'b0;
        end else begin
            // weight row and feature row land one cycle after the read
            wgt_load_o   <= wgt_re_o ? (`SA_COLS'(1) << wcnt_q) : '0;
            feat_valid_o <= feat_re_o;
            case (state_q)
                S_IDLE: begin
                    if (job_valid_i) begin
                        num_rows_q <= job_i.num_rows;
                        wcnt_q     <= '0;
                        issued_q   <= '0;
                        done_q     <= '0;
                        state_q    <= S_WFETCH;
                    end
                end
                S_WFETCH: begin
                    wcnt_q <= wcnt_q + 1'b1;
                    if (wcnt_q == LAST_WGT) begin
                        state_q <= S_STREAM;
                    end
                end
                S_STREAM: begin
                    if (feat_re_o) begin
                        issued_q <= issued_q + 1'b1;
                    end
                    if (sum_valid_i) begin
                        done_q <= done_q + 1'b1;
                        if (last_row) begin
                            state_q <= S_IDLE;
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // credit scheme keeps the FIFO from overflowing
    a_no_push_full: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        fifo_push_o |-> fifo_count_i < `SA_FIFO_DEPTH);

endmodule

/* design/pe_array.sv */
`timescale 1ns/1ps
`include "sa_cfg.svh"

module pe_array
    import sa_pkg::*;
(
    input  logic                          clk_i,
    input  logic                          rd_weight_rst,
    input  logic [`SA_COLS-1:0]           wgt_load_i,
    input  mem_row_t                      wgt_row_i,
    input  logic                          feat_valid_i,
    input  mem_row_t                      feat_row_i,
    output logic                          sum_valid_o,
    output logic [`SA_COLS*`SA_RES_W-1:0] sums_o
);

    mem_row_t            wgt_q [`SA_COLS];
    logic [`SA_COLS-1:0] col_valid;

    ////////////////////
    // weight bank
    ////////////////////

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            for (int c = 0; c < `SA_COLS; c++) wgt_q[c] <= '0;
        end else begin
            for (int c = 0; c < `SA_COLS; c++) begin
                if (wgt_load_i[c]) begin
                    wgt_q[c] <= wgt_row_i;
                end
            end
        end
    end

    // one feature row shared by all columns
    for (genvar c = 0; c < `SA_COLS; c++) begin : g_col
        dot_product_pipe u_col (
            .clk_i         (clk_i),
            .rd_weight_rst (rd_weight_rst),
            .valid_i       (feat_valid_i),
            .feat_i        (feat_row_i),
            .wgt_i         (wgt_q[c]),
            .valid_o       (col_valid[c]),
            .sum_o         (sums_o[c*`SA_RES_W +: `SA_RES_W])
        );
    end

    // columns run in lockstep
    assign sum_valid_o = &col_valid;

    a_load_onehot: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        $onehot0(wgt_load_i));

endmodule

/* design/dot_product_pipe.sv */
`timescale 1ns/1ps
`include "sa_cfg.svh"

module dot_product_pipe
    import sa_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rd_weight_rst,
    input  logic                 valid_i,
    input  mem_row_t             feat_i,
    input  mem_row_t             wgt_i,
    output logic                 valid_o,
    output logic [`SA_RES_W-1:0] sum_o
);

    localparam int N1 = `SA_ROWS / 2;
    localparam int N2 = `SA_ROWS / 4;
    localparam int N3 = `SA_ROWS / 8;
    // multiply plus four tree levels
    localparam int STAGES = $clog2(`SA_ROWS) + 1;

    logic [`SA_RES_W-1:0] prod_q [`SA_ROWS];
    logic [`SA_RES_W-1:0] lvl1_q [N1];
    logic [`SA_RES_W-1:0] lvl2_q [N2];
    logic [`SA_RES_W-1:0] lvl3_q [N3];
    logic [STAGES-1:0]    vld_q;

    // signed 8x8 product, low 16 bits
    function automatic logic [`SA_RES_W-1:0] mul8(input logic signed [`SA_DATA_W-1:0] a,
                                                  input logic signed [`SA_DATA_W-1:0] b);
        logic signed [`SA_RES_W-1:0] a_x;
        logic signed [`SA_RES_W-1:0] b_x;
        a_x = a;
        b_x = b;
        return a_x * b_x;
    endfunction

    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            for (int k = 0; k < `SA_ROWS; k++) prod_q[k] <= '0;
            for (int k = 0; k < N1; k++) lvl1_q[k] <= '0;
            for (int k = 0; k < N2; k++) lvl2_q[k] <= '0;
            for (int k = 0; k < N3; k++) lvl3_q[k] <= '0;
            sum_o <= '0;
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[STAGES-2:0], valid_i};
            for (int k = 0; k < `SA_ROWS; k++) begin
                prod_q[k] <= mul8(feat_i.lane[k], wgt_i.lane[k]);
            end
            // adder tree, sums wrap at 16 bits
            for (int k = 0; k < N1; k++) lvl1_q[k] <= prod_q[2*k] + prod_q[2*k+1];
            for (int k = 0; k < N2; k++) lvl2_q[k] <= lvl1_q[2*k] + lvl1_q[2*k+1];
            for (int k = 0; k < N3; k++) lvl3_q[k] <= lvl2_q[2*k] + lvl2_q[2*k+1];
            sum_o <= lvl3_q[0] + lvl3_q[1];
        end
    end

    assign valid_o = vld_q[STAGES-1];

endmodule

/* design/row_memory.sv */
`timescale 1ns/1ps

module row_memory
    import sa_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic                     clk_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] waddr_i,
    input  mem_row_t                 wdata_i,
    input  logic                     re_i,
    input  logic [$clog2(DEPTH)-1:0] raddr_i,
    output mem_row_t                 rdata_o
);

    mem_row_t mem [DEPTH];

    // write port
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // read port, data one cycle after re_i
    always_ff @(posedge clk_i) begin
        if (re_i) begin
            rdata_o <= mem[raddr_i];
        end
    end

endmodule

/* design/dram_row_packer.sv */
`timescale 1ns/1ps
`include "sa_cfg.svh"

module dram_row_packer
    import sa_pkg::*;
(
    input  logic                               clk_i,
    input  logic                               rd_weight_rst,
    input  logic                               load_valid_i,
    input  load_beat_t                         load_beat_i,
    input  logic                               busy_i,
    output logic                               load_ready_o,
    output logic                               feat_we_o,
    output logic [$clog2(`SA_FEAT_DEPTH)-1:0]  feat_waddr_o,
    output logic                               wgt_we_o,
    output logic [$clog2(`SA_WGT_DEPTH)-1:0]   wgt_waddr_o,
    output mem_row_t                           row_o
);

    localparam int BCNT_W = $clog2(`SA_BEATS_PER_ROW);
    localparam logic [BCNT_W-1:0] LAST_BEAT = BCNT_W'(`SA_BEATS_PER_ROW - 1);
    localparam int ROW_W = $bits(mem_row_t);

    logic [BCNT_W-1:0] beat_cnt_q;
    logic              tgt_q;
    logic              we_q;
    logic              busy_q;
    mem_row_t          row_q;
    logic              accept;

    assign load_ready_o = !busy_i;
    assign accept       = load_valid_i && load_ready_o;

    // new beats enter at the top, so beat 0 ends in lanes 0..3
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            beat_cnt_q <= '0;
            tgt_q      <= 1'b0;
            we_q       <= 1'b0;
            row_q      <= '0;
        end else begin
            we_q <= accept && (beat_cnt_q == LAST_BEAT);
            if (accept) begin
                row_q      <= {load_beat_i.data, row_q[ROW_W-1:`SA_BEAT_W]};
                beat_cnt_q <= beat_cnt_q + 1'b1;
                if (beat_cnt_q == '0) begin
                    tgt_q <= load_beat_i.is_wgt;
                end
            end
        end
    end

    // per target write pointers, rewound at job start
    always_ff @(posedge clk_i or posedge rd_weight_rst) begin
        if (rd_weight_rst) begin
            busy_q       <= 1'b0;
            feat_waddr_o <= '0;
            wgt_waddr_o  <= '0;
        end else begin
            busy_q <= busy_i;
            if (busy_i && !busy_q) begin
                feat_waddr_o <= '0;
                wgt_waddr_o  <= '0;
            end else if (we_q && tgt_q) begin
                wgt_waddr_o <= wgt_waddr_o + 1'b1;
            end else if (we_q) begin
                feat_waddr_o <= feat_waddr_o + 1'b1;
            end
        end
    end

    assign feat_we_o = we_q && !tgt_q;
    assign wgt_we_o  = we_q && tgt_q;
    assign row_o     = row_q;

    // a row comes from one target only
    a_row_target: assert property (@(posedge clk_i) disable iff (rd_weight_rst)
        accept && (beat_cnt_q != '0) |-> load_beat_i.is_wgt == tgt_q);

endmodule

/* design/sa_pkg.sv */
`include "sa_cfg.svh"

package sa_pkg;

    // one DRAM beat, is_wgt selects the weight memory
    typedef struct packed {
        logic                  is_wgt;
        logic [`SA_BEAT_W-1:0] data;
    } load_beat_t;

    // lane k sits at bits 8k+7 down to 8k
    typedef struct packed {
        logic [`SA_ROWS-1:0][`SA_DATA_W-1:0] lane;
    } mem_row_t;

    // rows to process, 1 to SA_FEAT_DEPTH
    typedef struct packed {
        logic [$clog2(`SA_FEAT_DEPTH+1)-1:0] num_rows;
    } job_req_t;

    // column c at bits 16c+15 down to 16c
    typedef struct packed {
        logic                               last;
        logic [$clog2(`SA_FEAT_DEPTH)-1:0]  row_idx;
        logic [`SA_COLS-1:0][`SA_RES_W-1:0] sum;
    } result_t;

endpackage

/* design/sa_cfg.svh */
`ifndef SA_CFG_SVH
`define SA_CFG_SVH

////////////////////
// array shape
////////////////////

// features per row, lanes per column
`define SA_ROWS 16
// filters, one per column
`define SA_COLS 4
// feature and weight width
`define SA_DATA_W 8
// column result width, wraps modulo 2^16
`define SA_RES_W 16

////////////////////
// memories and load path
////////////////////

`define SA_BEAT_W 32
`define SA_BEATS_PER_ROW 4
`define SA_FEAT_DEPTH 16
`define SA_WGT_DEPTH 4

// read request to column result: read, multiply, 4 tree levels
`define SA_PIPE_LAT 6

`define SA_FIFO_DEPTH 8

`endif
